// File: hdl/accel_driver.sv
module accel_driver import accel_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  // job intake
  input  job_t    cmd,
  input  logic    cmd_valid,
  output logic    cmd_ready,
  // towards the three stages
  output job_t    job,
  output logic    start,
  input  logic    done,
  input  data_t   done_sum,
  // report out
  output report_t report,
  output logic    report_valid,
  input  logic    report_ready
);

  // **************************************************
  // cycle counter and stamps
  // **************************************************

  cycle_t cycle_cnt;
  cycle_t start_stamp;
  cycle_t end_stamp;
  data_t  sum_q;

  // free running, wraps around
  always_ff @(posedge clk) begin
    if (rst) begin
      cycle_cnt <= '0;
    end else begin
      cycle_cnt <= cycle_cnt + cycle_t'(1);
    end
  end

  // **************************************************
  // driver FSM
  // **************************************************

  drv_state_t state;
  drv_state_t state_nxt;

  always_comb begin
    state_nxt = state;
    case (state)
      // wait for a job descriptor
      drv_idle: begin
        if (cmd_valid) begin
          state_nxt = drv_start;
        end
      end
      // single cycle, start pulse goes out here
      drv_start: begin
        state_nxt = drv_await;
      end
      // accelerator busy until done
      drv_await: begin
        if (done) begin
          state_nxt = drv_report;
        end
      end
      // report held until taken
      drv_report: begin
        if (report_ready) begin
          state_nxt = drv_idle;
        end
      end
      default: begin
        state_nxt = drv_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= drv_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // job latched on intake, stamps at start and at done
  always_ff @(posedge clk) begin
    if (state == drv_idle && cmd_valid) begin
      job <= cmd;
    end
    if (state == drv_start) begin
      start_stamp <= cycle_cnt;
    end
    if (state == drv_await && done) begin
      end_stamp <= cycle_cnt;
      sum_q     <= done_sum;
    end
  end

  // outputs decoded from state
  assign cmd_ready    = (state == drv_idle);
  assign start        = (state == drv_start);
  assign report_valid = (state == drv_report);
  // elapsed cycles, modulo counter width
  assign report = '{sum: sum_q, cycles: end_stamp - start_stamp};

endmodule

// File: hdl/accel_pkg.sv
package accel_pkg;

  // **************************************************
  // widths with a meaning
  // **************************************************

  // word address into the external memory
  typedef logic [15:0] addr_t;

  // one memory word
  typedef logic [31:0] data_t;

  // signed operand, low half of a memory word
  typedef logic signed [15:0] operand_t;

  // element pairs per job
  typedef logic [7:0] len_t;

  // cycle counter and elapsed cycles
  typedef logic [31:0] cycle_t;

  // **************************************************
  // bundles
  // **************************************************

  // job descriptor, 56 bits
  typedef struct packed {
    addr_t src_a;
    addr_t src_b;
    addr_t dst;
    len_t  len;
  } job_t;

  // read request, address only
  typedef struct packed {
    addr_t addr;
  } rd_req_t;

  // write request, 48 bits
  typedef struct packed {
    addr_t addr;
    data_t data;
  } wr_req_t;

  // report back to the host side, 64 bits
  typedef struct packed {
    data_t  sum;
    cycle_t cycles;
  } report_t;

  // driver FSM
  typedef enum logic [1:0] {
    drv_idle,
    drv_start,
    drv_await,
    drv_report
  } drv_state_t;

endpackage

// File: hdl/accel_top.sv
module accel_top import accel_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  // job in
  input  job_t    cmd,
  input  logic    cmd_valid,
  output logic    cmd_ready,
  // report out
  output report_t report,
  output logic    report_valid,
  input  logic    report_ready,
  // memory read side
  output rd_req_t rd_req,
  output logic    rd_req_valid,
  input  logic    rd_req_ready,
  input  data_t   rd_data,
  input  logic    rd_data_valid,
  // memory write side
  output wr_req_t wr_req,
  output logic    wr_req_valid,
  input  logic    wr_req_ready,
  input  logic    wr_ack
);

  // **************************************************
  // internal wiring
  // **************************************************

  job_t  job;
  logic  start;
  data_t sum;
  logic  sum_valid;
  logic  sum_ready;
  logic  done;
  data_t done_sum;

  // job intake, timing and report
  accel_driver driver_i (
    .clk          (clk),
    .rst          (rst),
    .cmd          (cmd),
    .cmd_valid    (cmd_valid),
    .cmd_ready    (cmd_ready),
    .job          (job),
    .start        (start),
    .done         (done),
    .done_sum     (done_sum),
    .report       (report),
    .report_valid (report_valid),
    .report_ready (report_ready)
  );

  // decode, operand addresses
  operand_fetch fetch_i (
    .clk          (clk),
    .rst          (rst),
    .job          (job),
    .start        (start),
    .rd_req       (rd_req),
    .rd_req_valid (rd_req_valid),
    .rd_req_ready (rd_req_ready)
  );

  // execute, multiply and accumulate
  mac_execute mac_i (
    .clk           (clk),
    .rst           (rst),
    .job           (job),
    .start         (start),
    .rd_data       (rd_data),
    .rd_data_valid (rd_data_valid),
    .sum           (sum),
    .sum_valid     (sum_valid),
    .sum_ready     (sum_ready)
  );

  // result, write back and done
  result_writeback wb_i (
    .clk          (clk),
    .rst          (rst),
    .job          (job),
    .sum          (sum),
    .sum_valid    (sum_valid),
    .sum_ready    (sum_ready),
    .wr_req       (wr_req),
    .wr_req_valid (wr_req_valid),
    .wr_req_ready (wr_req_ready),
    .wr_ack       (wr_ack),
    .done         (done),
    .done_sum     (done_sum)
  );

endmodule

// File: hdl/mac_execute.sv
module mac_execute import accel_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  job_t  job,
  input  logic  start,
  // memory responses, always accepted
  input  data_t rd_data,
  input  logic  rd_data_valid,
  // sum towards result stage
  output data_t sum,
  output logic  sum_valid,
  input  logic  sum_ready
);

  // **************************************************
  // response counting and accumulate
  // **************************************************

  // responses still expected, up to 2 * 255
  logic [8:0]         rsp_left;
  logic               busy;
  operand_t           a_q;
  data_t              acc;
  logic signed [31:0] product;

  // odd response times the latched a
  assign product = a_q * operand_t'(rd_data[15:0]);

  always_ff @(posedge clk) begin
    if (rst) begin
      busy      <= 1'b0;
      rsp_left  <= '0;
      sum_valid <= 1'b0;
    end else if (start) begin
      rsp_left  <= {job.len, 1'b0};
      busy      <= (job.len != '0);
      // nothing to fetch, sum of zero right away
      sum_valid <= (job.len == '0);
    end else begin
      if (busy && rd_data_valid) begin
        rsp_left <= rsp_left - 9'd1;
        if (rsp_left == 9'd1) begin
          busy      <= 1'b0;
          sum_valid <= 1'b1;
        end
      end
      if (sum_valid && sum_ready) begin
        sum_valid <= 1'b0;
      end
    end
  end

  // even count left means this response is an a operand
  always_ff @(posedge clk) begin
    if (start) begin
      acc <= '0;
    end else if (busy && rd_data_valid) begin
      if (!rsp_left[0]) begin
        a_q <= operand_t'(rd_data[15:0]);
      end else begin
        acc <= acc + data_t'(product);
      end
    end
  end

  assign sum = acc;

endmodule

// File: hdl/operand_fetch.sv
module operand_fetch import accel_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  job_t    job,
  input  logic    start,
  // read request port
  output rd_req_t rd_req,
  output logic    rd_req_valid,
  input  logic    rd_req_ready
);

  // **************************************************
  // element index and a/b phase
  // **************************************************

  logic  busy;
  len_t  idx;
  // low means the a operand is next
  logic  phase_b;
  logic  accept;
  logic  last_pair;
  addr_t base;

  assign accept = rd_req_valid && rd_req_ready;
  // last element pair of the job
  assign last_pair = (idx == job.len - len_t'(1));

  always_ff @(posedge clk) begin
    if (rst) begin
      busy    <= 1'b0;
      idx     <= '0;
      phase_b <= 1'b0;
    end else if (start) begin
      // zero length job issues nothing
      busy    <= (job.len != '0);
      idx     <= '0;
      phase_b <= 1'b0;
    end else if (accept) begin
      if (phase_b) begin
        // pair complete, step to next element
        idx     <= idx + len_t'(1);
        phase_b <= 1'b0;
        if (last_pair) begin
          busy <= 1'b0;
        end
      end else begin
        phase_b <= 1'b1;
      end
    end
  end

  // **************************************************
  // address stream
  // **************************************************

  // a, b, a, b ... all from registered state so it holds under stall
  assign base         = phase_b ? job.src_b : job.src_a;
  assign rd_req       = '{addr: base + addr_t'(idx)};
  assign rd_req_valid = busy;

endmodule

// File: hdl/result_writeback.sv
module result_writeback import accel_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  job_t    job,
  // sum from execute stage
  input  data_t   sum,
  input  logic    sum_valid,
  output logic    sum_ready,
  // write port
  output wr_req_t wr_req,
  output logic    wr_req_valid,
  input  logic    wr_req_ready,
  input  logic    wr_ack,
  // completion towards driver
  output logic    done,
  output data_t   done_sum
);

  // **************************************************
  // writeback FSM
  // **************************************************

  typedef enum logic [1:0] {
    wb_idle,
    wb_write,
    wb_wait
  } wb_state_t;

  wb_state_t state;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= wb_idle;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        wb_idle: begin
          if (sum_valid) begin
            state <= wb_write;
          end
        end
        wb_write: begin
          if (wr_req_ready) begin
            state <= wb_wait;
          end
        end
        // one ack per accepted write
        wb_wait: begin
          if (wr_ack) begin
            state <= wb_idle;
            done  <= 1'b1;
          end
        end
        default: begin
          state <= wb_idle;
        end
      endcase
    end
  end

  // sum kept for the write and for the report
  always_ff @(posedge clk) begin
    if (state == wb_idle && sum_valid) begin
      done_sum <= sum;
    end
  end

  assign sum_ready    = (state == wb_idle);
  assign wr_req_valid = (state == wb_write);
  // dst stays put, driver holds the job until the report goes out
  assign wr_req       = '{addr: job.dst, data: done_sum};

endmodule

// File: list.f
hdl/accel_pkg.sv
hdl/accel_driver.sv
hdl/operand_fetch.sv
hdl/mac_execute.sv
hdl/result_writeback.sv
hdl/accel_top.sv
verif/mem_model.sv
verif/accel_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f list.f --top-module accel_tb -Mdir obj_dir -o accel_sim

./obj_dir/accel_sim | tee sim.log

if grep -q "^Done: no errors$" sim.log; then
  exit 0
else
  exit 1
fi

// File: verif/accel_tb.sv
module accel_tb import accel_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_jobs = 12;

  logic    clk = 1'b0;
  logic    rst;
  job_t    cmd;
  logic    cmd_valid;
  logic    cmd_ready;
  report_t report;
  logic    report_valid;
  logic    report_ready;
  rd_req_t rd_req;
  logic    rd_req_valid;
  logic    rd_req_ready;
  data_t   rd_data;
  logic    rd_data_valid;
  wr_req_t wr_req;
  logic    wr_req_valid;
  logic    wr_req_ready;
  logic    wr_ack;

  logic [31:0] lfsr;
  job_t        jobs [16];
  data_t       exp_sums [16];
  // reference copy of memory
  data_t       ref_mem [256];
  int          limit_cycles = 0;
  int          errors = 0;
  int          mem_errors;

  // monitor state, current job = reports done so far
  logic [3:0] rep_cnt;
  int         rd_seen;
  logic       in_flight;
  job_t       cur_job;
  data_t      cur_sum;
  addr_t      exp_rd_addr;
  int         exp_reads;

  always #5 clk = ~clk;

  accel_top dut_i (.*);

  mem_model mem_i (.*);

  // galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  // **************************************************
  // bookkeeping on the rising edge
  // **************************************************

  always @(posedge clk) begin
    if (rst) begin
      rep_cnt   <= '0;
      rd_seen   <= 0;
      in_flight <= 1'b0;
    end else begin
      if (cmd_valid && cmd_ready) begin
        rd_seen   <= 0;
        in_flight <= 1'b1;
      end
      if (rd_req_valid && rd_req_ready) begin
        rd_seen <= rd_seen + 1;
      end
      if (report_valid && report_ready) begin
        rep_cnt   <= rep_cnt + 4'd1;
        in_flight <= 1'b0;
      end
    end
  end

  assign cur_job   = jobs[rep_cnt];
  assign cur_sum   = exp_sums[rep_cnt];
  assign exp_reads = 2 * int'(cur_job.len);
  // even reads from a, odd from b
  assign exp_rd_addr = (rd_seen[0] ? cur_job.src_b : cur_job.src_a) + addr_t'(rd_seen >> 1);

  // **************************************************
  // checks
  // **************************************************

  sum_matches: assert property (@(posedge clk) disable iff (rst)
    report_valid && report_ready |-> report.sum == cur_sum)
    else begin
      errors = errors + 1;
      $display("mismatch report_sum: expected %h, actual %h", $sampled(cur_sum),
               $sampled(report.sum));
    end

  write_addr_matches: assert property (@(posedge clk) disable iff (rst)
    wr_req_valid && wr_req_ready |-> wr_req.addr == cur_job.dst)
    else begin
      errors = errors + 1;
      $display("mismatch writeback: expected %h, actual %h", $sampled(cur_job.dst),
               $sampled(wr_req.addr));
    end

  write_data_matches: assert property (@(posedge clk) disable iff (rst)
    wr_req_valid && wr_req_ready |-> wr_req.data == cur_sum)
    else begin
      errors = errors + 1;
      $display("mismatch writeback: expected %h, actual %h", $sampled(cur_sum),
               $sampled(wr_req.data));
    end

  read_addr_in_order: assert property (@(posedge clk) disable iff (rst)
    rd_req_valid && rd_req_ready |-> rd_req.addr == exp_rd_addr)
    else begin
      errors = errors + 1;
      $display("mismatch read_order: expected %h, actual %h", $sampled(exp_rd_addr),
               $sampled(rd_req.addr));
    end

  read_count_matches: assert property (@(posedge clk) disable iff (rst)
    report_valid && report_ready |-> rd_seen == exp_reads)
    else begin
      errors = errors + 1;
      $display("mismatch read_order: expected %0d, actual %0d", $sampled(exp_reads),
               $sampled(rd_seen));
    end

  no_extra_reads: assert property (@(posedge clk) disable iff (rst)
    rd_req_valid |-> rd_seen < exp_reads)
    else begin
      errors = errors + 1;
      $display("read_order: read request beyond the job's 2*len reads");
    end

  rd_req_holds: assert property (@(posedge clk) disable iff (rst)
    rd_req_valid && !rd_req_ready |=> rd_req_valid && $stable(rd_req))
    else begin
      errors = errors + 1;
      $display("handshake_hold: read request dropped or changed while stalled");
    end

  wr_req_holds: assert property (@(posedge clk) disable iff (rst)
    wr_req_valid && !wr_req_ready |=> wr_req_valid && $stable(wr_req))
    else begin
      errors = errors + 1;
      $display("handshake_hold: write request dropped or changed while stalled");
    end

  report_holds: assert property (@(posedge clk) disable iff (rst)
    report_valid && !report_ready |=> report_valid && $stable(report))
    else begin
      errors = errors + 1;
      $display("handshake_hold: report dropped or changed while stalled");
    end

  busy_blocks_cmd: assert property (@(posedge clk) disable iff (rst)
    in_flight |-> !cmd_ready)
    else begin
      errors = errors + 1;
      $display("handshake_hold: cmd_ready high while a job is still in flight");
    end

  cycles_above_floor: assert property (@(posedge clk) disable iff (rst)
    report_valid && report_ready |-> report.cycles >= cycle_t'(exp_reads + 2))
    else begin
      errors = errors + 1;
      $display("cycles_bound: report gave %0d cycles, fewer than possible",
               $sampled(report.cycles));
    end

  quiet_in_reset: assert property (@(posedge clk)
    rst |=> !rd_req_valid && !wr_req_valid && !report_valid)
    else begin
      errors = errors + 1;
      $display("reset_idle: a valid output was high during or right after reset");
    end

  // **************************************************
  // stimulus
  // **************************************************

  // report back-pressure, one cycle in four
  initial begin
    logic [31:0] v;
    report_ready = 1'b0;
    forever begin
      @(negedge clk);
      take_bits(2, v);
      report_ready = (v[1:0] != 2'b00);
    end
  end

  initial begin
    logic [31:0]        v;
    len_t               len;
    data_t              acc;
    operand_t           a;
    operand_t           b;
    logic signed [31:0] prod;
    int                 total;
    lfsr      = 32'h375e;
    rst       = 1'b1;
    cmd       = '0;
    cmd_valid = 1'b0;
    total     = 0;
    // lengths 0, 1, 16, then random up to 20
    for (int k = 0; k < num_jobs; k++) begin
      take_bits(5, v);
      len = (k == 0) ? len_t'(0) : (k == 1) ? len_t'(1) : (k == 2) ? len_t'(16) :
            len_t'(v % 21);
      // a, b and dst packed back to back, disjoint modulo 256
      take_bits(16, v);
      jobs[k].src_a = addr_t'(v);
      jobs[k].src_b = jobs[k].src_a + addr_t'(len);
      jobs[k].dst   = jobs[k].src_b + addr_t'(len);
      jobs[k].len   = len;
      total         = total + int'(len);
    end
    limit_cycles = 200 * total + 500;

    repeat (3) @(negedge clk);
    rst = 1'b0;

    // expected sums, jobs run one after another
    for (int i = 0; i < 256; i++) begin
      ref_mem[8'(i)] = mem_i.mem[8'(i)];
    end
    for (int k = 0; k < num_jobs; k++) begin
      acc = '0;
      for (int i = 0; i < int'(jobs[k].len); i++) begin
        a    = operand_t'(ref_mem[8'(jobs[k].src_a + addr_t'(i))][15:0]);
        b    = operand_t'(ref_mem[8'(jobs[k].src_b + addr_t'(i))][15:0]);
        prod = a * b;
        acc  = acc + data_t'(prod);
      end
      exp_sums[k]                  = acc;
      ref_mem[jobs[k].dst[7:0]]    = acc;
    end

    for (int k = 0; k < num_jobs; k++) begin
      @(negedge clk);
      cmd       = jobs[k];
      cmd_valid = 1'b1;
      while (!cmd_ready) begin
        @(negedge clk);
      end
      @(negedge clk);
      cmd_valid = 1'b0;
      // report taken, next job
      while (int'(rep_cnt) <= k) begin
        @(negedge clk);
      end
    end
    repeat (2) @(negedge clk);

    // whole memory against the reference copy
    mem_errors = 0;
    for (int i = 0; i < 256; i++) begin
      assert (mem_i.mem[8'(i)] == ref_mem[8'(i)])
      else begin
        mem_errors = mem_errors + 1;
        $display("mismatch writeback: word %0d expected %h, actual %h", i,
                 ref_mem[8'(i)], mem_i.mem[8'(i)]);
      end
    end

    $display("reports %0d of %0d, check errors %0d, memory errors %0d", rep_cnt, num_jobs,
             errors, mem_errors);
    if (errors == 0 && mem_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // watchdog, sized from the total element pairs
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: jobs did not finish within %0d cycles", limit_cycles);
    $display("Done: errors found");
    $finish;
  end

endmodule

// File: verif/mem_model.sv
module mem_model import accel_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  // read side
  input  rd_req_t rd_req,
  input  logic    rd_req_valid,
  output logic    rd_req_ready,
  output data_t   rd_data,
  output logic    rd_data_valid,
  // write side
  input  wr_req_t wr_req,
  input  logic    wr_req_valid,
  output logic    wr_req_ready,
  output logic    wr_ack
);
  timeunit 1ns;
  timeprecision 1ps;

  // **************************************************
  // storage and random source
  // **************************************************

  // 256 words with the address wrapping on the low byte
  data_t       mem [256];
  logic [31:0] lfsr;

  // rising edge view of both request ports
  logic    rd_fire;
  addr_t   rd_addr_q;
  logic    wr_fire;
  wr_req_t wr_q;

  // reads in flight with the oldest first
  addr_t pend_addr [$];
  int    pend_due [$];
  int    cyc;

  // galois form with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one step per bit
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  // transfers land on the rising edge
  always @(posedge clk) begin
    rd_fire   <= !rst && rd_req_valid && rd_req_ready;
    rd_addr_q <= rd_req.addr;
    wr_fire   <= !rst && wr_req_valid && wr_req_ready;
    wr_q      <= wr_req;
  end

  // **************************************************
  // falling edge side drives everything
  // **************************************************

  initial begin
    logic [31:0] v;
    addr_t       a;
    lfsr          = 32'h375e;
    rd_req_ready  = 1'b0;
    rd_data       = '0;
    rd_data_valid = 1'b0;
    wr_req_ready  = 1'b0;
    wr_ack        = 1'b0;
    cyc           = 0;
    for (int i = 0; i < 256; i++) begin
      take_bits(32, v);
      mem[8'(i)] = v;
    end
    forever begin
      @(negedge clk);
      cyc++;
      // response latency 1 to 4 cycles
      if (rd_fire) begin
        take_bits(2, v);
        pend_addr.push_back(rd_addr_q);
        pend_due.push_back(cyc + int'(v[1:0]));
      end
      if (wr_fire) begin
        mem[wr_q.addr[7:0]] = wr_q.data;
      end
      // one ack per accepted write
      wr_ack        = wr_fire;
      rd_data_valid = 1'b0;
      if (pend_addr.size() > 0 && pend_due[0] <= cyc) begin
        a             = pend_addr.pop_front();
        void'(pend_due.pop_front());
        rd_data       = mem[a[7:0]];
        rd_data_valid = 1'b1;
      end
      // ready three times in four
      take_bits(2, v);
      rd_req_ready = (v[1:0] != 2'b00);
      take_bits(2, v);
      wr_req_ready = (v[1:0] != 2'b00);
    end
  end

endmodule
